/* rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ==============================
// Core widths
// ==============================

`define RV_XLEN        32
`define RV_REG_BITS    5

// Instruction memory is word aligned, so the two low address bits stay zero
`define RV_IADDR_BITS  16

// First fetch after reset
`define RV_RESET_ADDR  0

`endif

/* rv_isa_pkg.sv */
`include "rv_macros.svh"

package rv_isa_pkg;

    // Only the major opcodes this core executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // ALU funct3 codes, shared by OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B      // LUI passes the U immediate straight through
    } alu_op_t;

    typedef struct packed {
        logic [6:0]              funct7;
        logic [`RV_REG_BITS-1:0] rs2;
        logic [`RV_REG_BITS-1:0] rs1;
        logic [2:0]              funct3;
        logic [`RV_REG_BITS-1:0] rd;
        opcode_t                 opcode;
    } instr_fields_t;

endpackage

/* rv_pipe_pkg.sv */
`include "rv_macros.svh"

package rv_pipe_pkg;

    typedef struct packed {
        logic                      valid;
        logic [`RV_IADDR_BITS-1:0] pc;
        logic [`RV_XLEN-1:0]       instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic                      valid;
        logic [`RV_IADDR_BITS-1:0] pc;
        logic [`RV_REG_BITS-1:0]   rs1;
        logic [`RV_REG_BITS-1:0]   rs2;
        logic [`RV_REG_BITS-1:0]   rd;
        logic [`RV_XLEN-1:0]       rdata1;
        logic [`RV_XLEN-1:0]       rdata2;
        logic [`RV_XLEN-1:0]       imm;
        rv_isa_pkg::alu_op_t       alu_op;
        logic                      use_imm;
        logic                      reg_write;
        logic                      is_load;
        logic                      is_store;
        logic                      is_branch;
        logic                      branch_ne;    // BNE when set, BEQ otherwise
    } exec_pkt_t;

    typedef struct packed {
        logic                    valid;
        logic [`RV_REG_BITS-1:0] rd;
        logic                    reg_write;
        logic                    is_load;
        logic [`RV_XLEN-1:0]     result;         // ALU result or load/store byte address
    } mem_pkt_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        logic                req;
        logic                we;
        logic [`RV_XLEN-1:0] addr;    // Word index, the byte address shifted right by two
        logic [`RV_XLEN-1:0] wdata;
    } data_req_t;

endpackage

/* rv_fetch.sv */
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_fetch
(
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_stall,
    input  logic                       i_redirect,
    input  logic [`RV_IADDR_BITS-1:0]  i_redirect_pc,
    input  logic [`RV_XLEN-1:0]        i_instr_data,
    output logic [`RV_IADDR_BITS-1:0]  o_instr_addr,
    output rv_pipe_pkg::fetch_pkt_t    o_fetch
);
    import rv_pipe_pkg::*;

    logic [`RV_IADDR_BITS-1:0] pc;
    logic [`RV_IADDR_BITS-1:0] inflight_pc;    // Address of the word now on i_instr_data
    logic                      inflight_valid;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            pc             <= `RV_IADDR_BITS'(`RV_RESET_ADDR);
            inflight_valid <= 1'b0;
        end
        else if (i_redirect)
        begin
            pc             <= i_redirect_pc;
            inflight_valid <= 1'b0;             // Word returning next cycle is wrong path
        end
        else if (!i_stall)
        begin
            pc             <= pc + `RV_IADDR_BITS'(4);
            inflight_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
            inflight_pc <= pc;
    end

    // While stalled the returned word is not taken, so ask for it again
    assign o_instr_addr = i_stall ? inflight_pc : pc;

    assign o_fetch.valid = inflight_valid;
    assign o_fetch.pc    = inflight_pc;
    assign o_fetch.instr = i_instr_data;

endmodule

/* rv_pipe_reg.sv */
`timescale 1ns/1ps

module rv_pipe_reg
#(
    parameter type T = logic
)
(
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_stall,
    input  logic i_flush,
    input  T     i_d,
    output T     o_q
);

    // An all-zero payload carries valid low, so flush inserts a bubble
    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
            o_q <= '0;
        else if (!i_stall)
            o_q <= i_d;
    end

endmodule

/* rv_decode.sv */
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_decode
(
    input  rv_pipe_pkg::fetch_pkt_t    i_fetch,
    input  logic [`RV_XLEN-1:0]        i_rdata1,
    input  logic [`RV_XLEN-1:0]        i_rdata2,
    output logic [`RV_REG_BITS-1:0]    o_rs1,
    output logic [`RV_REG_BITS-1:0]    o_rs2,
    output rv_pipe_pkg::exec_pkt_t     o_exec
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    instr_fields_t       f;
    funct3_t             f3;
    logic [`RV_XLEN-1:0] ins;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic                is_shift;
    logic                supported;

    function automatic alu_op_t alu_sel(input funct3_t fn, input logic alt);
        case (fn)
            F3_ADD_SUB: alu_sel = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_sel = ALU_SLL;
            F3_SLT:     alu_sel = ALU_SLT;
            F3_SLTU:    alu_sel = ALU_SLTU;
            F3_XOR:     alu_sel = ALU_XOR;
            F3_SRL_SRA: alu_sel = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_sel = ALU_OR;
            default:    alu_sel = ALU_AND;
        endcase
    endfunction

    assign ins = i_fetch.instr;
    assign f   = ins;
    assign f3  = funct3_t'(f.funct3);

    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {ins[31:12], 12'b0};

    assign is_shift = (f3 == F3_SLL) || (f3 == F3_SRL_SRA);

    assign o_rs1 = f.rs1;
    assign o_rs2 = f.rs2;

    always_comb
    begin
        supported     = 1'b0;
        o_exec        = '0;
        o_exec.pc     = i_fetch.pc;
        o_exec.rs1    = f.rs1;
        o_exec.rs2    = f.rs2;
        o_exec.rd     = f.rd;
        o_exec.rdata1 = i_rdata1;
        o_exec.rdata2 = i_rdata2;
        o_exec.alu_op = ALU_ADD;    // Address adder for loads and stores
        case (f.opcode)
            OPC_OP:
            begin
                supported = (f.funct7 == 7'b0000000) ||
                            (f.funct7 == 7'b0100000 && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
                o_exec.alu_op    = alu_sel(f3, f.funct7[5]);
                o_exec.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                // Shift immediates carry funct7, only SRAI may set bit 30
                supported = !is_shift || (f.funct7 == 7'b0000000) ||
                            (f3 == F3_SRL_SRA && f.funct7 == 7'b0100000);
                o_exec.alu_op    = alu_sel(f3, f3 == F3_SRL_SRA && f.funct7[5]);
                o_exec.imm       = imm_i;
                o_exec.use_imm   = 1'b1;
                o_exec.reg_write = 1'b1;
            end
            OPC_LUI:
            begin
                supported        = 1'b1;
                o_exec.alu_op    = ALU_PASS_B;
                o_exec.imm       = imm_u;
                o_exec.use_imm   = 1'b1;
                o_exec.reg_write = 1'b1;
            end
            OPC_LOAD:
            begin
                supported        = (f.funct3 == 3'b010);    // LW only
                o_exec.imm       = imm_i;
                o_exec.use_imm   = 1'b1;
                o_exec.reg_write = 1'b1;
                o_exec.is_load   = 1'b1;
            end
            OPC_STORE:
            begin
                supported       = (f.funct3 == 3'b010);     // SW only
                o_exec.imm      = imm_s;
                o_exec.use_imm  = 1'b1;
                o_exec.is_store = 1'b1;
            end
            OPC_BRANCH:
            begin
                supported        = (f.funct3[2:1] == 2'b00);    // BEQ and BNE
                o_exec.imm       = imm_b;
                o_exec.is_branch = 1'b1;
                o_exec.branch_ne = f.funct3[0];
            end
            default:
            begin
                supported = 1'b0;
            end
        endcase
        o_exec.valid = i_fetch.valid && supported;
    end

endmodule

/* rv_regs.sv */
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_regs
(
    input  logic                     i_clk,
    input  logic [`RV_REG_BITS-1:0]  i_rs1,
    input  logic [`RV_REG_BITS-1:0]  i_rs2,
    input  logic                     i_we,
    input  logic [`RV_REG_BITS-1:0]  i_rd,
    input  logic [`RV_XLEN-1:0]      i_wdata,
    output logic [`RV_XLEN-1:0]      o_rdata1,
    output logic [`RV_XLEN-1:0]      o_rdata2
);

    logic [`RV_XLEN-1:0] regs [31:1];    // x0 has no storage

    always_ff @(posedge i_clk)
    begin
        if (i_we && i_rd != '0)
            regs[i_rd] <= i_wdata;
    end

    // Write-first, so decode sees a result retiring in the same cycle
    always_comb
    begin
        o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
        if (i_we && i_rd == i_rs1 && i_rs1 != '0)
            o_rdata1 = i_wdata;
        o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];
        if (i_we && i_rd == i_rs2 && i_rs2 != '0)
            o_rdata2 = i_wdata;
    end

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_execute
(
    input  rv_pipe_pkg::exec_pkt_t     i_exec,
    input  rv_pipe_pkg::fwd_sel_t      i_fwd1,
    input  rv_pipe_pkg::fwd_sel_t      i_fwd2,
    input  logic [`RV_XLEN-1:0]        i_mem_result,
    input  logic [`RV_XLEN-1:0]        i_wb_data,
    output rv_pipe_pkg::mem_pkt_t      o_mem,
    output logic [`RV_XLEN-1:0]        o_store_data,
    output logic                       o_branch_taken,
    output logic [`RV_IADDR_BITS-1:0]  o_branch_pc
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_rs2;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [4:0]          shamt;

    // ==============================
    // Operand forwarding
    // ==============================
    assign op_a   = (i_fwd1 == FWD_MEM) ? i_mem_result :
                    (i_fwd1 == FWD_WB)  ? i_wb_data : i_exec.rdata1;
    assign op_rs2 = (i_fwd2 == FWD_MEM) ? i_mem_result :
                    (i_fwd2 == FWD_WB)  ? i_wb_data : i_exec.rdata2;
    assign op_b   = i_exec.use_imm ? i_exec.imm : op_rs2;
    assign shamt  = op_b[4:0];

    // ==============================
    // ALU
    // ==============================
    always_comb
    begin
        case (i_exec.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = `RV_XLEN'($signed(op_a) >>> shamt);
            default:    alu_res = op_b;    // PASS_B
        endcase
    end

    assign o_mem.valid     = i_exec.valid;
    assign o_mem.rd        = i_exec.rd;
    assign o_mem.reg_write = i_exec.valid && i_exec.reg_write;
    assign o_mem.is_load   = i_exec.valid && i_exec.is_load;
    assign o_mem.result    = alu_res;

    assign o_store_data = op_rs2;

    // Branch resolves here, the target is relative to the branch itself
    assign o_branch_taken = i_exec.valid && i_exec.is_branch &&
                            ((op_a == op_rs2) ^ i_exec.branch_ne);
    assign o_branch_pc    = i_exec.pc + i_exec.imm[`RV_IADDR_BITS-1:0];

endmodule

/* rv_hazard.sv */
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_hazard
(
    input  logic [`RV_REG_BITS-1:0]  i_dec_rs1,
    input  logic [`RV_REG_BITS-1:0]  i_dec_rs2,
    input  logic [`RV_REG_BITS-1:0]  i_ex_rd,
    input  logic                     i_ex_is_load,
    input  logic                     i_ex_valid,
    input  logic [`RV_REG_BITS-1:0]  i_ex_rs1,
    input  logic [`RV_REG_BITS-1:0]  i_ex_rs2,
    input  rv_pipe_pkg::mem_pkt_t    i_mem,
    input  logic [`RV_REG_BITS-1:0]  i_wb_rd,
    input  logic                     i_wb_we,
    input  logic                     i_branch_taken,
    output logic                     o_stall,
    output logic                     o_flush_dec,
    output logic                     o_flush_ex,
    output rv_pipe_pkg::fwd_sel_t    o_fwd1,
    output rv_pipe_pkg::fwd_sel_t    o_fwd2
);
    import rv_pipe_pkg::*;

    // Memory stage is younger than write-back, so it wins
    function automatic fwd_sel_t fwd_pick(input logic [`RV_REG_BITS-1:0] rs,
                                          input mem_pkt_t mem,
                                          input logic [`RV_REG_BITS-1:0] wb_rd,
                                          input logic wb_we);
        if (rs == '0)
            fwd_pick = FWD_REG;
        else if (mem.valid && mem.reg_write && mem.rd == rs)
            fwd_pick = FWD_MEM;
        else if (wb_we && wb_rd == rs)
            fwd_pick = FWD_WB;
        else
            fwd_pick = FWD_REG;
    endfunction

    // Load data is only ready in write-back, one cycle too late for the next instruction
    assign o_stall = i_ex_valid && i_ex_is_load && i_ex_rd != '0 &&
                     (i_ex_rd == i_dec_rs1 || i_ex_rd == i_dec_rs2);

    assign o_flush_dec = i_branch_taken;
    assign o_flush_ex  = i_branch_taken || o_stall;    // Stall sends a bubble into execute

    assign o_fwd1 = fwd_pick(i_ex_rs1, i_mem, i_wb_rd, i_wb_we);
    assign o_fwd2 = fwd_pick(i_ex_rs2, i_mem, i_wb_rd, i_wb_we);

endmodule

/* rv_writeback.sv */
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_writeback
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  rv_pipe_pkg::mem_pkt_t    i_mem,
    input  logic [`RV_XLEN-1:0]      i_store_data,
    input  logic                     i_is_store,
    input  logic [`RV_XLEN-1:0]      i_data_rdata,
    output rv_pipe_pkg::data_req_t   o_data,
    output rv_pipe_pkg::mem_pkt_t    o_mem_stage,
    output logic [`RV_REG_BITS-1:0]  o_wb_rd,
    output logic                     o_wb_we,
    output logic [`RV_XLEN-1:0]      o_wb_data
);
    import rv_pipe_pkg::*;

    mem_pkt_t            mem_q;
    mem_pkt_t            wb_q;
    logic                store_q;
    logic [`RV_XLEN-1:0] store_data_q;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            mem_q   <= '0;
            wb_q    <= '0;
            store_q <= 1'b0;
        end
        else
        begin
            mem_q   <= i_mem;
            wb_q    <= mem_q;
            store_q <= i_mem.valid && i_is_store;
        end
    end

    always_ff @(posedge i_clk)
    begin
        store_data_q <= i_store_data;
    end

    // ==============================
    // Memory stage
    // ==============================
    assign o_data.req   = mem_q.is_load || store_q;
    assign o_data.we    = store_q;
    assign o_data.addr  = {2'b00, mem_q.result[`RV_XLEN-1:2]};
    assign o_data.wdata = store_data_q;

    assign o_mem_stage = mem_q;

    // ==============================
    // Write-back stage
    // ==============================
    assign o_wb_rd   = wb_q.rd;
    assign o_wb_we   = wb_q.valid && wb_q.reg_write;
    assign o_wb_data = wb_q.is_load ? i_data_rdata : wb_q.result;    // Load word lands now

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_core
(
    input  logic                       i_clk,
    input  logic                       i_reset,
    output logic [`RV_IADDR_BITS-1:0]  o_instr_addr,
    input  logic [`RV_XLEN-1:0]        i_instr_data,
    output rv_pipe_pkg::data_req_t     o_data,
    input  logic [`RV_XLEN-1:0]        i_data_rdata
);
    import rv_pipe_pkg::*;

    fetch_pkt_t                fetch_pkt;
    fetch_pkt_t                dec_pkt;
    exec_pkt_t                 exec_d;
    exec_pkt_t                 exec_q;
    mem_pkt_t                  mem_d;
    mem_pkt_t                  mem_stage;
    fwd_sel_t                  fwd1;
    fwd_sel_t                  fwd2;
    logic [`RV_REG_BITS-1:0]   dec_rs1;
    logic [`RV_REG_BITS-1:0]   dec_rs2;
    logic [`RV_XLEN-1:0]       rdata1;
    logic [`RV_XLEN-1:0]       rdata2;
    logic [`RV_XLEN-1:0]       store_data;
    logic                      branch_taken;
    logic [`RV_IADDR_BITS-1:0] branch_pc;
    logic                      stall;
    logic                      flush_dec;
    logic                      flush_ex;
    logic [`RV_REG_BITS-1:0]   wb_rd;
    logic                      wb_we;
    logic [`RV_XLEN-1:0]       wb_data;

    rv_fetch u_fetch
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (stall),
        .i_redirect     (branch_taken),
        .i_redirect_pc  (branch_pc),
        .i_instr_data   (i_instr_data),
        .o_instr_addr   (o_instr_addr),
        .o_fetch        (fetch_pkt)
    );

    rv_pipe_reg #(.T(fetch_pkt_t)) u_dec_reg
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (stall),
        .i_flush        (flush_dec),
        .i_d            (fetch_pkt),
        .o_q            (dec_pkt)
    );

    rv_decode u_decode
    (
        .i_fetch        (dec_pkt),
        .i_rdata1       (rdata1),
        .i_rdata2       (rdata2),
        .o_rs1          (dec_rs1),
        .o_rs2          (dec_rs2),
        .o_exec         (exec_d)
    );

    rv_regs u_regs
    (
        .i_clk          (i_clk),
        .i_rs1          (dec_rs1),
        .i_rs2          (dec_rs2),
        .i_we           (wb_we),
        .i_rd           (wb_rd),
        .i_wdata        (wb_data),
        .o_rdata1       (rdata1),
        .o_rdata2       (rdata2)
    );

    // Execute never holds, a load-use stall bubbles it through flush
    rv_pipe_reg #(.T(exec_pkt_t)) u_exec_reg
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (1'b0),
        .i_flush        (flush_ex),
        .i_d            (exec_d),
        .o_q            (exec_q)
    );

    rv_execute u_execute
    (
        .i_exec         (exec_q),
        .i_fwd1         (fwd1),
        .i_fwd2         (fwd2),
        .i_mem_result   (mem_stage.result),
        .i_wb_data      (wb_data),
        .o_mem          (mem_d),
        .o_store_data   (store_data),
        .o_branch_taken (branch_taken),
        .o_branch_pc    (branch_pc)
    );

    rv_hazard u_hazard
    (
        .i_dec_rs1      (dec_rs1),
        .i_dec_rs2      (dec_rs2),
        .i_ex_rd        (exec_q.rd),
        .i_ex_is_load   (exec_q.is_load),
        .i_ex_valid     (exec_q.valid),
        .i_ex_rs1       (exec_q.rs1),
        .i_ex_rs2       (exec_q.rs2),
        .i_mem          (mem_stage),
        .i_wb_rd        (wb_rd),
        .i_wb_we        (wb_we),
        .i_branch_taken (branch_taken),
        .o_stall        (stall),
        .o_flush_dec    (flush_dec),
        .o_flush_ex     (flush_ex),
        .o_fwd1         (fwd1),
        .o_fwd2         (fwd2)
    );

    rv_writeback u_writeback
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_mem          (mem_d),
        .i_store_data   (store_data),
        .i_is_store     (exec_q.is_store),
        .i_data_rdata   (i_data_rdata),
        .o_data         (o_data),
        .o_mem_stage    (mem_stage),
        .o_wb_rd        (wb_rd),
        .o_wb_we        (wb_we),
        .o_wb_data      (wb_data)
    );

endmodule

/* rv_core_tb.sv */
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_core_tb;
    import rv_pipe_pkg::*;

    localparam int          PROG_LEN     = 64;
    localparam int          NUM_REGS     = 5;                      // Programs use x0 to x4
    localparam int          TOTAL_INSTRS = PROG_LEN + NUM_REGS;    // Tail stores every register
    localparam int          DMEM_WORDS   = 64;
    localparam int          MAX_CYCLES   = 6 * TOTAL_INSTRS + 40;
    localparam int          DRIVE_DELAY  = 1;
    localparam logic [31:0] NOP          = 32'h0000_0013;

    localparam int K_OP  = 0;
    localparam int K_IMM = 1;
    localparam int K_LUI = 2;
    localparam int K_LW  = 3;
    localparam int K_SW  = 4;
    localparam int K_BR  = 5;

    logic                      i_clk;
    logic                      i_reset;
    logic [`RV_IADDR_BITS-1:0] o_instr_addr;
    logic [`RV_XLEN-1:0]       i_instr_data;
    data_req_t                 o_data;
    logic [`RV_XLEN-1:0]       i_data_rdata;

    integer      seed = 35715;
    int          mismatches = 0;
    int          errors = 0;
    int          checks = 0;
    int          stores_seen = 0;
    int          exp_total = 0;
    int          cycles = 0;
    logic [31:0] instr_next;
    logic [31:0] rdata_next;

    int          ins_kind [0:TOTAL_INSTRS-1];
    logic [4:0]  ins_rd   [0:TOTAL_INSTRS-1];
    logic [4:0]  ins_rs1  [0:TOTAL_INSTRS-1];
    logic [4:0]  ins_rs2  [0:TOTAL_INSTRS-1];
    logic [2:0]  ins_f3   [0:TOTAL_INSTRS-1];
    logic        ins_alt  [0:TOTAL_INSTRS-1];
    logic [31:0] ins_imm  [0:TOTAL_INSTRS-1];
    logic [31:0] prog     [0:TOTAL_INSTRS-1];
    logic [31:0] dmem     [0:DMEM_WORDS-1];
    logic [31:0] ref_mem  [0:DMEM_WORDS-1];
    data_req_t   exp_q    [$];

    rv_core rv_core_i
    (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .o_instr_addr (o_instr_addr),
        .i_instr_data (i_instr_data),
        .o_data       (o_data),
        .i_data_rdata (i_data_rdata)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // ==============================
    // Program and reference model
    // ==============================
    function automatic int unsigned pick(input int unsigned n);
        pick = $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] encode(input int i);
        logic [31:0] w;
        logic [11:0] i12;
        w   = NOP;
        i12 = ins_imm[i][11:0];
        if (ins_kind[i] == K_IMM && (ins_f3[i] == 3'd1 || ins_f3[i] == 3'd5))
            i12 = {ins_alt[i] ? 7'b0100000 : 7'b0000000, ins_imm[i][4:0]};
        case (ins_kind[i])
            K_OP:  w = {ins_alt[i] ? 7'b0100000 : 7'b0000000, ins_rs2[i], ins_rs1[i],
                        ins_f3[i], ins_rd[i], 7'b0110011};
            K_IMM: w = {i12, ins_rs1[i], ins_f3[i], ins_rd[i], 7'b0010011};
            K_LUI: w = {ins_imm[i][31:12], ins_rd[i], 7'b0110111};
            K_LW:  w = {i12, ins_rs1[i], 3'b010, ins_rd[i], 7'b0000011};
            K_SW:  w = {i12[11:5], ins_rs2[i], ins_rs1[i], 3'b010, i12[4:0], 7'b0100011};
            K_BR:  w = {ins_imm[i][12], ins_imm[i][10:5], ins_rs2[i], ins_rs1[i], ins_f3[i],
                        ins_imm[i][4:1], ins_imm[i][11], 7'b1100011};
            default: w = NOP;
        endcase
        encode = w;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    alu_ref = alt ? a - b : a + b;
            3'd1:    alu_ref = a << b[4:0];
            3'd2:    alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    alu_ref = (a < b) ? 32'd1 : 32'd0;
            3'd4:    alu_ref = a ^ b;
            3'd5:
            begin
                // Arithmetic shift copies the sign bit of a into the vacated bits
                if (alt)
                    alu_ref = $signed(a) >>> b[4:0];
                else
                    alu_ref = a >> b[4:0];
            end
            3'd6:    alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    task automatic build_program();
        int          sel;
        int          i;
        logic [31:0] r;
        for (i = 0; i < DMEM_WORDS; i++)
        begin
            dmem[i]    = $random(seed);
            ref_mem[i] = dmem[i];
        end
        for (i = 0; i < TOTAL_INSTRS; i++)
        begin
            ins_rd[i]  = 5'(pick(NUM_REGS));
            ins_rs1[i] = 5'(pick(NUM_REGS));
            ins_rs2[i] = 5'(pick(NUM_REGS));
            ins_f3[i]  = 3'(pick(8));
            ins_alt[i] = 1'b0;
            r          = $random(seed);
            ins_imm[i] = {{20{r[11]}}, r[11:0]};
            sel        = int'(pick(16));
            if (i < NUM_REGS - 1)
            begin
                // Register file has no reset, so x1 to x4 get a value first
                ins_kind[i] = K_IMM;
                ins_f3[i]   = 3'd0;
                ins_rs1[i]  = 5'd0;
                ins_rd[i]   = 5'(i + 1);
            end
            else if (i >= PROG_LEN)
            begin
                ins_kind[i] = K_SW;
                ins_rs1[i]  = 5'd0;
                ins_rs2[i]  = 5'(i - PROG_LEN);
                ins_imm[i]  = 32'((32 + i - PROG_LEN) * 4);
            end
            else if (sel < 6)
            begin
                ins_kind[i] = K_OP;
                ins_alt[i]  = (ins_f3[i] == 3'd0 || ins_f3[i] == 3'd5) ? 1'(pick(2)) : 1'b0;
            end
            else if (sel < 10)
            begin
                ins_kind[i] = K_IMM;
                if (ins_f3[i] == 3'd1 || ins_f3[i] == 3'd5)
                    ins_imm[i] = 32'(pick(32));
                ins_alt[i] = (ins_f3[i] == 3'd5) ? 1'(pick(2)) : 1'b0;
            end
            else if (sel == 10)
            begin
                ins_kind[i] = K_LUI;
                ins_imm[i]  = {r[31:12], 12'b0};
            end
            else if (sel < 14)
            begin
                ins_kind[i] = (sel == 13) ? K_SW : K_LW;
                ins_rs1[i]  = 5'd0;              // Base x0 keeps addresses inside the memory
                ins_imm[i]  = 32'(pick(32) * 4);
            end
            else if (i <= PROG_LEN - 3)
            begin
                ins_kind[i] = K_BR;
                ins_f3[i]   = 3'(pick(2));
                ins_imm[i]  = pick(2) ? 32'd12 : 32'd8;
            end
            else
            begin
                ins_kind[i] = K_OP;
            end
            prog[i] = encode(i);
        end
    endtask

    task automatic run_model();
        logic [31:0] x [0:31];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        data_req_t   st;
        int          pc;
        int          step;
        int          r;
        for (r = 0; r < 32; r++)
            x[r] = '0;
        pc = 0;
        while (pc < TOTAL_INSTRS)
        begin
            a    = x[ins_rs1[pc]];
            b    = x[ins_rs2[pc]];
            res  = a + ins_imm[pc];
            step = 1;
            case (ins_kind[pc])
                K_OP:  res = alu_ref(ins_f3[pc], ins_alt[pc], a, b);
                K_IMM: res = alu_ref(ins_f3[pc], ins_alt[pc], a, ins_imm[pc]);
                K_LUI: res = ins_imm[pc];
                K_LW:  res = ref_mem[res[7:2]];
                K_SW:
                begin
                    st.req   = 1'b1;
                    st.we    = 1'b1;
                    st.addr  = {2'b00, res[31:2]};
                    st.wdata = b;
                    exp_q.push_back(st);
                    ref_mem[res[7:2]] = b;
                end
                default:
                begin
                    if ((a == b) ^ ins_f3[pc][0])
                        step = int'(ins_imm[pc] >> 2);
                end
            endcase
            if (ins_kind[pc] <= K_LW && ins_rd[pc] != 5'd0)
                x[ins_rd[pc]] = res;
            pc = pc + step;
        end
    endtask

    // ==============================
    // Checks and memory models
    // ==============================
    task automatic check_store(input string name, input data_req_t exp, input data_req_t act);
        checks++;
        if (act !== exp)
        begin
            mismatches++;
            $display("Mismatch %s: expected addr %h data %h, actual addr %h data %h",
                     name, exp.addr, exp.wdata, act.addr, act.wdata);
        end
    endtask

    task automatic check_addr(input string name, input logic [`RV_IADDR_BITS-1:0] exp,
                              input logic [`RV_IADDR_BITS-1:0] act);
        checks++;
        if (act !== exp)
        begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            mismatches++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic take_store(input data_req_t req);
        stores_seen++;
        if (exp_q.size() == 0)
        begin
            errors++;
            $display("Store %0d to word %h came after all %0d stores of the program",
                     stores_seen, req.addr, exp_total);
        end
        else
        begin
            check_store($sformatf("program store %0d", stores_seen), exp_q.pop_front(), req);
        end
        dmem[req.addr[5:0]] = req.wdata;
    endtask

    function automatic logic [31:0] fetch_word(input logic [`RV_IADDR_BITS-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        fetch_word = (idx < TOTAL_INSTRS) ? prog[idx] : NOP;
    endfunction

    // Requests are taken mid-cycle and answered just after the next rising edge
    always @(negedge i_clk)
    begin
        instr_next = fetch_word(o_instr_addr);
        if (!i_reset && o_data.req && !o_data.we)
            rdata_next = dmem[o_data.addr[5:0]];
        if (!i_reset && o_data.req && o_data.we)
            take_store(o_data);
    end

    always @(posedge i_clk)
    begin
        #(DRIVE_DELAY);
        i_instr_data = instr_next;
        i_data_rdata = rdata_next;
    end

    // ==============================
    // Main sequence and timeout
    // ==============================
    initial
    begin
        i_reset      = 1'b1;
        i_instr_data = NOP;
        i_data_rdata = '0;
        instr_next   = NOP;
        rdata_next   = '0;
        build_program();
        run_model();
        exp_total = exp_q.size();
        repeat (5) @(posedge i_clk);
        #(DRIVE_DELAY);
        i_reset = 1'b0;
        @(negedge i_clk);
        check_addr("reset fetch address", `RV_IADDR_BITS'(`RV_RESET_ADDR), o_instr_addr);
        check_flag("reset data req", 1'b0, o_data.req);
        check_flag("reset data we", 1'b0, o_data.we);
        @(negedge i_clk);
        check_addr("second fetch address", `RV_IADDR_BITS'(`RV_RESET_ADDR + 4), o_instr_addr);
        while (stores_seen < exp_total)
            @(posedge i_clk);
        repeat (20) @(posedge i_clk);    // NOPs past the program must not store
        if (stores_seen != exp_total)
        begin
            errors++;
            $display("Saw %0d stores but the program makes %0d", stores_seen, exp_total);
        end
        $display("Checks %0d, mismatches %0d, other errors %0d, stores %0d of %0d",
                 checks, mismatches, errors, stores_seen, exp_total);
        if (mismatches == 0 && errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        while (cycles < MAX_CYCLES)
        begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d stores seen",
                 cycles, stores_seen, exp_total);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_fetch.sv
rv_pipe_reg.sv
rv_decode.sv
rv_regs.sv
rv_execute.sv
rv_hazard.sv
rv_writeback.sv
rv_core.sv
rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
LINT_TOP  ?= rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
